/* Bender.yml */
package:
  name: exe_unit

sources:
  - src/alu_pkg.sv
  - src/rv_pkg.sv
  - src/alu_decoder.sv
  - src/op_fifo.sv
  - src/alu.sv
  - src/alu_execute.sv
  - src/exe_unit.sv
  - target: simulation
    files:
      - sim/tb_exe_unit.sv

/* sim/exe_patterns.hex */
// columns: instr rs1 rs2 expected
// expected is {illegal, rd[4:0], zero, sign, result[31:0]}
002080B3 00000005 00000007 040000000C
40208133 00000005 00000007 09FFFFFFFE
002091B3 00000003 00000024 0C00000030
0020A233 FFFFFFFF 00000001 1100000001
0020B2B3 FFFFFFFF 00000001 1700000000
0020C333 12345678 12345678 1A00000000
0020D3B3 80000000 00000021 1C40000000
4020D433 80000000 00000004 21F8000000
0020E4B3 0F0F0000 000000F0 240F0F00F0
0020F533 FF00FF00 0F0F0F0F 280F000F00
022085B3 00000001 00000002 8000000000
FFB08613 00000003 00000099 31FFFFFFFE
01F09693 00000001 00000000 3580000000
4080D713 80000000 00000000 39FF800000
FFF0A793 00000000 00000000 3E00000000
FFF0B813 00000005 00000000 4000000001
40109893 00000001 00000000 8000000000
ABCDE937 00000000 00000000 49ABCDE000
FFF0C993 0000FFFF 00000000 4DFFFF0000
00000003 00000000 00000000 8000000000

/* sim/tb_exe_unit.sv */
// ----------------------------------------
// execute subsystem testbench
// ----------------------------------------
module tb_exe_unit;
	timeunit 1ns;
	timeprecision 1ps;
	import alu_pkg::*;
	import rv_pkg::*;

	// records in the pattern file with four words per record
	localparam int n_rec = 20;
	localparam int timeout_cyc = 200;

	logic                 clk;
	logic                 rst;
	logic                 instr_valid;
	logic [31:0]          instr;
	logic [data_len-1:0]  rs1_data;
	logic [data_len-1:0]  rs2_data;
	logic                 hold;
	logic                 busy;
	logic                 illegal;
	logic                 result_valid;
	logic [data_len-1:0]  result;
	logic                 zero;
	logic                 sign;
	logic [reg_idx_w-1:0] rd;

	// words per record are instr rs1 rs2 and expected
	logic [39:0] pat [0:4*n_rec-1];
	// expected words of legal ops in issue order
	logic [39:0] exp_q [$];
	int          illegal_exp;
	int          illegal_seen;
	logic        seen_busy;

	exe_unit u_dut (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.hold         (hold),
		.busy         (busy),
		.illegal      (illegal),
		.result_valid (result_valid),
		.result       (result),
		.zero         (zero),
		.sign         (sign),
		.rd           (rd)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		stop_run();
	endtask

	task automatic check_word(input string name, input logic [data_len-1:0] exp,
		input logic [data_len-1:0] act);
		if (act !== exp) begin
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail at %0d ns: %s expected %b, got %b", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_rd(input string name, input logic [reg_idx_w-1:0] exp,
		input logic [reg_idx_w-1:0] act);
		if (act !== exp) begin
			$display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	// oldest expected word against the current result
	task automatic check_result();
		logic [39:0] exp;
		if (exp_q.size() == 0) begin
			report_failure("result_valid pulsed with no legal instruction pending");
		end else begin
			exp = exp_q.pop_front();
			check_word("result", exp[31:0], result);
			check_bit("zero", exp[33], zero);
			check_bit("sign", exp[32], sign);
			check_rd("rd", exp[38:34], rd);
		end
	endtask

	// outputs are settled by the falling edge
	initial begin
		forever begin
			@(negedge clk);
			if (!rst) begin
				if (busy) seen_busy = 1'b1;
				if (illegal) illegal_seen++;
				if (result_valid) check_result();
			end
		end
	end

	// random stall bursts from writeback
	initial begin
		hold = 1'b0;
		repeat (6) @(posedge clk);
		forever begin
			#2 hold = 1'b1;
			repeat (4 + $urandom % 8) @(posedge clk);
			#2 hold = 1'b0;
			repeat (1 + $urandom % 4) @(posedge clk);
		end
	end

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (busy) begin
			@(posedge clk);
			#2;
			n++;
			if (n > timeout_cyc) report_failure("busy stayed high for 200 cycles");
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() > 0) begin
			@(posedge clk);
			n++;
			if (n > timeout_cyc) report_failure("results missing after 200 cycles");
		end
	endtask

	// one strobe that queues the expected word of a legal op
	task automatic send_record(input int idx);
		logic [39:0] exp;
		instr       = pat[4*idx][31:0];
		rs1_data    = pat[4*idx+1][data_len-1:0];
		rs2_data    = pat[4*idx+2][data_len-1:0];
		exp         = pat[4*idx+3];
		instr_valid = 1'b1;
		if (exp[39]) illegal_exp++;
		else exp_q.push_back(exp);
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
	endtask

	initial begin
		int gap;
		void'($urandom(32'hbc82));
		rst          = 1'b1;
		instr_valid  = 1'b0;
		instr        = '0;
		rs1_data     = '0;
		rs2_data     = '0;
		illegal_exp  = 0;
		illegal_seen = 0;
		seen_busy    = 1'b0;
		$readmemh("sim/exe_patterns.hex", pat);
		repeat (5) @(posedge clk);
		#2 rst = 1'b0;
		// quiet outputs straight after reset
		check_bit("result_valid", 1'b0, result_valid);
		check_bit("illegal", 1'b0, illegal);
		check_bit("busy", 1'b0, busy);
		for (int i = 0; i < n_rec; i++) begin
			wait_not_busy();
			send_record(i);
			gap = $urandom % 3;
			repeat (gap) begin
				@(posedge clk);
				#2;
			end
		end
		wait_drain();
		// idle tail to catch stray pulses
		repeat (4) @(posedge clk);
		if (illegal_seen != illegal_exp) begin
			report_failure($sformatf("saw %0d illegal pulses, wanted %0d",
				illegal_seen, illegal_exp));
		end else if (!seen_busy) begin
			report_failure("busy never rose during the stall bursts");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* sources.f */
src/alu_pkg.sv
src/rv_pkg.sv
src/alu_decoder.sv
src/op_fifo.sv
src/alu.sv
src/alu_execute.sv
src/exe_unit.sv
sim/tb_exe_unit.sv

/* src/alu.sv */
// ---------------------------------------
// rv32i integer alu
// ---------------------------------------
module alu (
	input  logic [alu_pkg::data_len-1:0] src1,
	input  logic [alu_pkg::data_len-1:0] src2,
	input  logic [alu_pkg::alu_op_w-1:0] alu_control,
	output logic [alu_pkg::data_len-1:0] result,
	output logic                         zero,
	output logic                         sign
);
	import alu_pkg::*;

	// raw value before slt reduction
	logic [data_len-1:0] raw;
	// difference with borrow out on top
	logic [data_len:0]   diff;
	logic                lt_s;
	logic                lt_u;

	assign diff = {1'b0, src1} - {1'b0, src2};
	// borrow means src1 below src2 unsigned
	assign lt_u = diff[data_len];
	// signs differ, src1 negative wins
	assign lt_s = (src1[data_len-1] ^ src2[data_len-1]) ? src1[data_len-1] :
		diff[data_len-1];

	always_comb begin
		case (alu_control)
			alu_add:    raw = src1 + src2;
			alu_sub:    raw = diff[data_len-1:0];
			alu_sll:    raw = src1 << src2;
			// compares keep the difference for sign
			alu_slt:    raw = diff[data_len-1:0];
			alu_sltu:   raw = diff[data_len-1:0];
			alu_xor:    raw = src1 ^ src2;
			alu_srl:    raw = src1 >> src2;
			alu_sra:    raw = $signed(src1) >>> src2;
			alu_or:     raw = src1 | src2;
			alu_and:    raw = src1 & src2;
			alu_pass_b: raw = src2;
			alu_srl5:   raw = src1 >> src2[4:0];
			alu_sll5:   raw = src1 << src2[4:0];
			alu_sra5:   raw = $signed(src1) >>> src2[4:0];
			default:    raw = '0;
		endcase
	end

	// slt and sltu reduce to a single bit
	always_comb begin
		case (alu_control)
			alu_slt:  result = {{(data_len - 1){1'b0}}, lt_s};
			alu_sltu: result = {{(data_len - 1){1'b0}}, lt_u};
			default:  result = raw;
		endcase
	end

	// zero looks at the final value
	assign zero = (result == '0);
	// sign looks at the raw value
	assign sign = raw[data_len-1];

endmodule

/* src/alu_decoder.sv */
// ---------------------------------------
// instruction to alu operation decoder
// ---------------------------------------
module alu_decoder (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         instr_valid,
	input  logic [31:0]                  instr,
	input  logic [alu_pkg::data_len-1:0] rs1_data,
	input  logic [alu_pkg::data_len-1:0] rs2_data,
	output logic                         push,
	output alu_pkg::alu_op_t             push_op,
	output logic                         illegal
);
	import alu_pkg::*;
	import rv_pkg::*;

	// instruction fields
	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [reg_idx_w-1:0] rd_idx;
	logic [data_len-1:0]  imm_i;
	logic [data_len-1:0]  imm_u;

	// combinational decode result
	logic [alu_op_w-1:0]  dec_op;
	logic [data_len-1:0]  dec_src1;
	logic [data_len-1:0]  dec_src2;
	logic                 dec_ok;

	assign opcode = instr[6:0];
	assign rd_idx = instr[11:7];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	// sign-extended i-type immediate
	assign imm_i  = {{(data_len - 12){instr[31]}}, instr[31:20]};
	// u-type immediate with the low 12 bits clear
	assign imm_u  = {instr[31:12], 12'b0};

	always_comb begin
		dec_op   = alu_add;
		dec_src1 = rs1_data;
		dec_src2 = rs2_data;
		dec_ok   = 1'b0;
		case (opcode)
			opc_op: begin
				// alt form only for sub and sra
				dec_ok = (funct7 == 7'd0) ||
					((funct7 == f7_alt) && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)));
				case (funct3)
					f3_add_sub: dec_op = (funct7 == f7_alt) ? alu_sub : alu_add;
					f3_sll:     dec_op = alu_sll5;
					f3_slt:     dec_op = alu_slt;
					f3_sltu:    dec_op = alu_sltu;
					f3_xor:     dec_op = alu_xor;
					f3_srl_sra: dec_op = (funct7 == f7_alt) ? alu_sra5 : alu_srl5;
					f3_or:      dec_op = alu_or;
					default:    dec_op = alu_and;
				endcase
			end
			opc_op_imm: begin
				dec_src2 = imm_i;
				dec_ok   = 1'b1;
				case (funct3)
					f3_add_sub: dec_op = alu_add;
					f3_sll: begin
						// slli has no alternate form
						dec_op = alu_sll5;
						dec_ok = (funct7 == 7'd0);
					end
					f3_slt:     dec_op = alu_slt;
					f3_sltu:    dec_op = alu_sltu;
					f3_xor:     dec_op = alu_xor;
					f3_srl_sra: begin
						dec_op = (funct7 == f7_alt) ? alu_sra5 : alu_srl5;
						dec_ok = (funct7 == 7'd0) || (funct7 == f7_alt);
					end
					f3_or:      dec_op = alu_or;
					default:    dec_op = alu_and;
				endcase
			end
			opc_lui: begin
				// upper immediate passes through src2
				dec_op   = alu_pass_b;
				dec_src1 = '0;
				dec_src2 = imm_u;
				dec_ok   = 1'b1;
			end
			default: dec_ok = 1'b0;
		endcase
	end

	// strobes follow instr_valid by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			push    <= 1'b0;
			illegal <= 1'b0;
		end else begin
			push    <= instr_valid && dec_ok;
			illegal <= instr_valid && !dec_ok;
		end
	end

	// payload registers, qualified downstream by push
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			push_op.op   <= dec_op;
			push_op.src1 <= dec_src1;
			push_op.src2 <= dec_src2;
			push_op.rd   <= rd_idx;
		end
	end

	// a queued op carries fully known fields
	assert property (@(posedge clk) disable iff (rst) push |-> !$isunknown(push_op));

endmodule

/* src/alu_execute.sv */
// ---------------------------------------
// execute stage
// ---------------------------------------
module alu_execute (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         empty,
	input  alu_pkg::alu_op_t             head_op,
	input  logic                         hold,
	output logic                         pop,
	output logic                         result_valid,
	output logic [alu_pkg::data_len-1:0] result,
	output logic                         zero,
	output logic                         sign,
	output logic [4:0]                   rd
);
	import alu_pkg::*;

	// alu outputs for the current head
	logic [data_len-1:0] alu_result;
	logic                alu_zero;
	logic                alu_sign;

	alu u_alu (
		.src1        (head_op.src1),
		.src2        (head_op.src2),
		.alu_control (head_op.op),
		.result      (alu_result),
		.zero        (alu_zero),
		.sign        (alu_sign)
	);

	// take the head unless writeback stalls
	assign pop = !empty && !hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= pop;
		end
	end

	// result registers load on a pop
	always_ff @(posedge clk) begin
		if (pop) begin
			result <= alu_result;
			zero   <= alu_zero;
			sign   <= alu_sign;
			rd     <= head_op.rd;
		end
	end

	// a popped head was written by the queue
	assert property (@(posedge clk) disable iff (rst) pop |-> !$isunknown(head_op));

endmodule

/* src/alu_pkg.sv */
// ---------------------------------------
// alu codes and queued operation
// ---------------------------------------
package alu_pkg;

	// operand and result width, one word
	localparam int data_len = 32;

	// width of an alu code
	localparam int alu_op_w = 4;

	// alu operation codes, 4-bit numbering
	localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
	localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
	// full-width shift, amount not masked
	localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
	localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
	localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
	localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
	localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
	localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
	localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
	localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
	// src2 straight through, used by lui
	localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;
	// shifts by the low 5 bits of src2
	localparam logic [alu_op_w-1:0] alu_srl5   = 4'd11;
	localparam logic [alu_op_w-1:0] alu_sll5   = 4'd12;
	localparam logic [alu_op_w-1:0] alu_sra5   = 4'd13;

	// operation queue entries
	localparam int fifo_depth = 4;

	// one queued operation, 73 bits
	typedef struct packed {
		// alu code
		logic [alu_op_w-1:0] op;
		// first operand
		logic [data_len-1:0] src1;
		// second operand or immediate
		logic [data_len-1:0] src2;
		// destination register index
		logic [4:0]          rd;
	} alu_op_t;

endpackage

/* src/exe_unit.sv */
// ---------------------------------------
// integer execute subsystem
// ---------------------------------------
module exe_unit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         instr_valid,
	input  logic [31:0]                  instr,
	input  logic [alu_pkg::data_len-1:0] rs1_data,
	input  logic [alu_pkg::data_len-1:0] rs2_data,
	input  logic                         hold,
	output logic                         busy,
	output logic                         illegal,
	output logic                         result_valid,
	output logic [alu_pkg::data_len-1:0] result,
	output logic                         zero,
	output logic                         sign,
	output logic [rv_pkg::reg_idx_w-1:0] rd
);
	import alu_pkg::*;

	// decoder to queue
	logic    push;
	alu_op_t push_op;

	// queue to execute and back
	logic    empty;
	logic    pop;
	alu_op_t head_op;

	// producer, one cycle decode
	alu_decoder u_decoder (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.push        (push),
		.push_op     (push_op),
		.illegal     (illegal)
	);

	// four-entry buffer
	op_fifo u_fifo (
		.clk     (clk),
		.rst     (rst),
		.push    (push),
		.push_op (push_op),
		.pop     (pop),
		.head_op (head_op),
		.empty   (empty),
		.busy    (busy)
	);

	// consumer, stalled by hold
	alu_execute u_execute (
		.clk          (clk),
		.rst          (rst),
		.empty        (empty),
		.head_op      (head_op),
		.hold         (hold),
		.pop          (pop),
		.result_valid (result_valid),
		.result       (result),
		.zero         (zero),
		.sign         (sign),
		.rd           (rd)
	);

endmodule

/* src/op_fifo.sv */
// ---------------------------------------
// alu operation queue
// ---------------------------------------
module op_fifo (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  alu_pkg::alu_op_t push_op,
	input  logic             pop,
	output alu_pkg::alu_op_t head_op,
	output logic             empty,
	output logic             busy
);
	import alu_pkg::*;

	// circular entry storage
	alu_op_t mem [fifo_depth];

	// pointers wrap on their own since the depth is a power of two
	logic [$clog2(fifo_depth)-1:0] wr_ptr;
	logic [$clog2(fifo_depth)-1:0] rd_ptr;
	// one extra bit to hold the full count
	logic [$clog2(fifo_depth):0]   count;
	logic                          full;

	assign head_op = mem[rd_ptr];
	assign empty   = (count == '0);
	assign full    = (count == ($clog2(fifo_depth) + 1)'(fifo_depth));
	// one slot kept free for the op still in the decoder
	assign busy    = (count >= ($clog2(fifo_depth) + 1)'(fifo_depth - 1));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_op;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// count moves only when one side is idle
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// decoder must respect busy upstream
	assert property (@(posedge clk) disable iff (rst) !(push && full));
	// execute only pops a valid head
	assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

/* src/rv_pkg.sv */
// ---------------------------------------
// rv32i field encodings
// ---------------------------------------
package rv_pkg;

	// register index width
	localparam int reg_idx_w = 5;

	// major opcodes handled here
	// register-register arithmetic
	localparam logic [6:0] opc_op     = 7'b0110011;
	// register-immediate arithmetic
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	// load upper immediate
	localparam logic [6:0] opc_lui    = 7'b0110111;

	// funct3 codes, shared by op and op-imm
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	// logical or arithmetic right shift
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct7 alternate form
	// selects sub and sra, also srai under op-imm
	localparam logic [6:0] f7_alt     = 7'b0100000;

endpackage
